/* source/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// ===========================================================================
// array and memory geometry
// ===========================================================================

// array is MMU_N x MMU_N, also lanes per memory row and rows per weight tile
`define MMU_N      4
`define MMU_DEPTH  16      // rows per memory
`define MMU_AW     4       // memory address width

// datapath widths
`define MMU_DW     8       // signed operand
`define MMU_SW     16      // signed sum, wraps mod 2^16

`endif

/* source/mmu_pkg.sv */
`include "mmu_config.svh"

package mmu_pkg;

    // one lane and one row of operands / sums
    typedef logic signed [`MMU_DW-1:0] act_t;
    typedef logic signed [`MMU_SW-1:0] sum_t;
    typedef act_t [`MMU_N-1:0] act_row_t;   // 32 bits at N=4
    typedef sum_t [`MMU_N-1:0] sum_row_t;   // 64 bits at N=4

    typedef enum logic [1:0] {
        op_none         = 2'd0,
        op_load_weights = 2'd1,
        op_compute      = 2'd2
    } mmu_op_e;

    // host command strobe, src_base is weight base or input base by op
    typedef struct packed {
        mmu_op_e             op;
        logic [`MMU_AW-1:0]  src_base;
        logic [`MMU_AW-1:0]  dst_base;
        logic [`MMU_AW:0]    count;      // 1..MMU_DEPTH vectors
    } host_cmd_t;

    typedef struct packed {
        logic                en;
        logic [`MMU_AW-1:0]  addr;
        act_row_t            data;
    } mem_wr_t;

    typedef enum logic {feed_idle, feed_run} feed_state_e;
    typedef enum logic [1:0] {load_idle, load_fetch, load_commit} load_state_e;

    // travels beside a vector so the writer knows its output row
    typedef struct packed {
        logic                valid;
        logic [`MMU_AW-1:0]  dst_addr;
    } wave_t;

endpackage

/* source/mac_cell.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module mac_cell (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic signed [`MMU_DW-1:0] a_in,
    input  logic signed [`MMU_DW-1:0] w_in,
    input  logic signed [`MMU_SW-1:0] s_in,
    input  logic                      w_shift_en,
    input  logic                      w_commit,
    output logic signed [`MMU_DW-1:0] a_out,
    output logic signed [`MMU_DW-1:0] w_out,
    output logic signed [`MMU_SW-1:0] s_out
);
    logic signed [`MMU_DW-1:0] w_shadow;   // filled by the shift chain
    logic signed [`MMU_DW-1:0] w_active;   // used by the multiplier
    logic signed [`MMU_SW-1:0] prod;

    assign prod = a_in * w_active;         // 8x8 signed, fits in 16

    // activation right, sum down
    always_ff @(posedge clk) begin
        a_out <= a_in;
        s_out <= s_in + prod;              // wraps mod 2^16
    end

    always_ff @(posedge clk) begin
        if (w_shift_en) begin
            w_shadow <= w_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_active <= '0;
        end else if (w_commit) begin
            w_active <= w_shadow;          // whole tile swaps at once
        end
    end

    assign w_out = w_shadow;               // next row's shadow source

endmodule

/* source/systolic_array.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module systolic_array (
    input  logic               clk,
    input  logic               rst_n,
    input  mmu_pkg::act_row_t  a_in,
    input  mmu_pkg::act_row_t  w_shift,
    input  logic               w_shift_en,
    input  logic               w_commit,
    output mmu_pkg::sum_row_t  psum_out
);
    import mmu_pkg::*;

    // a_bus[i][j] feeds cell (i,j) from the left, column N is the unused edge
    act_t a_bus [`MMU_N][`MMU_N+1];
    // w_bus[i][j] / s_bus[i][j] feed cell (i,j) from above
    act_t w_bus [`MMU_N+1][`MMU_N];
    sum_t s_bus [`MMU_N+1][`MMU_N];

    // =======================================================================
    // array edges
    // =======================================================================
    for (genvar k = 0; k < `MMU_N; k++) begin : g_edge
        assign a_bus[k][0] = a_in[k];        // row k gets lane k
        assign w_bus[0][k] = w_shift[k];     // weights enter at the top
        assign s_bus[0][k] = '0;             // no bias
        assign psum_out[k] = s_bus[`MMU_N][k];
    end

    // =======================================================================
    // cell grid
    // =======================================================================
    for (genvar i = 0; i < `MMU_N; i++) begin : g_row
        for (genvar j = 0; j < `MMU_N; j++) begin : g_col
            mac_cell cell_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .a_in       (a_bus[i][j]),
                .w_in       (w_bus[i][j]),
                .s_in       (s_bus[i][j]),
                .w_shift_en (w_shift_en),
                .w_commit   (w_commit),
                .a_out      (a_bus[i][j+1]),
                .w_out      (w_bus[i+1][j]),
                .s_out      (s_bus[i+1][j])
            );
        end
    end

endmodule

/* source/activation_feeder.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module activation_feeder (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::host_cmd_t  cmd,
    input  mmu_pkg::mem_wr_t    in_wr,
    output mmu_pkg::act_row_t   a_in,
    output mmu_pkg::wave_t      tag,
    output logic                busy
);
    import mmu_pkg::*;

    act_row_t            mem [`MMU_DEPTH];   // input memory
    feed_state_e         state;
    logic [`MMU_AW:0]    rd_ptr;             // extra bit exposes overrun
    logic [`MMU_AW-1:0]  dst_ptr;
    logic [`MMU_AW:0]    remaining;          // vectors left to read
    act_row_t            row_q;              // registered read data

    // host write port
    always_ff @(posedge clk) begin
        if (in_wr.en) begin
            mem[in_wr.addr] <= in_wr.data;
        end
    end

    // =======================================================================
    // read sequencer, one vector per cycle
    // =======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= feed_idle;
            rd_ptr    <= '0;
            dst_ptr   <= '0;
            remaining <= '0;
        end else begin
            case (state)
                feed_idle: begin
                    if (cmd.op == op_compute) begin
                        state     <= feed_run;
                        rd_ptr    <= {1'b0, cmd.src_base};
                        dst_ptr   <= cmd.dst_base;
                        remaining <= cmd.count;
                    end
                end
                feed_run: begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    dst_ptr   <= dst_ptr + 1'b1;     // dst_base + index
                    remaining <= remaining - 1'b1;
                    if (remaining == 1) begin
                        state <= feed_idle;          // last vector read this cycle
                    end
                end
                default: state <= feed_idle;
            endcase
        end
    end

    // tag lines up with lane 0 of row_q
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag <= '0;
        end else begin
            tag.valid    <= (state == feed_run);
            tag.dst_addr <= dst_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (state == feed_run) begin
            row_q <= mem[rd_ptr[`MMU_AW-1:0]];
        end else begin
            row_q <= '0;                             // idle lanes carry zeros
        end
    end

    // =======================================================================
    // triangular skew, lane i delayed i cycles
    // =======================================================================
    for (genvar i = 0; i < `MMU_N; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_in[0] = row_q[0];
        end else begin : g_delay
            act_t pipe [i];
            always_ff @(posedge clk) begin
                pipe[0] <= row_q[i];
                for (int d = 1; d < i; d++) begin
                    pipe[d] <= pipe[d-1];
                end
            end
            assign a_in[i] = pipe[i-1];
        end
    end

    assign busy = (state == feed_run);

    // host must keep src_base + count inside the memory, no wrap
    a_rd_in_range : assert property (@(posedge clk) disable iff (!rst_n)
        (state == feed_run) |-> (rd_ptr < `MMU_DEPTH));

endmodule

/* source/weight_loader.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module weight_loader (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::host_cmd_t  cmd,
    input  mmu_pkg::mem_wr_t    wt_wr,
    output mmu_pkg::act_row_t   w_shift,
    output logic                w_shift_en,
    output logic                w_commit,
    output logic                weight_done,
    output logic                busy
);
    import mmu_pkg::*;

    localparam int cnt_w = $clog2(`MMU_N + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`MMU_N);
    localparam logic [`MMU_AW-1:0] top_ofs = `MMU_AW'(`MMU_N - 1);

    act_row_t            mem [`MMU_DEPTH];   // weight memory
    load_state_e         state;
    logic [cnt_w-1:0]    cnt;                // 0 = read only, 1..N = shift
    logic [`MMU_AW-1:0]  rd_addr;

    // host write port
    always_ff @(posedge clk) begin
        if (wt_wr.en) begin
            mem[wt_wr.addr] <= wt_wr.data;
        end
    end

    // =======================================================================
    // fetch / shift / commit sequencer
    // =======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= load_idle;
            cnt   <= '0;
        end else begin
            case (state)
                load_idle: begin
                    if (cmd.op == op_load_weights) begin
                        state <= load_fetch;
                        cnt   <= '0;
                    end
                end
                load_fetch: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == last_cnt) begin
                        state <= load_commit;       // all N rows shifted in
                    end
                end
                load_commit: state <= load_idle;
                default:     state <= load_idle;
            endcase
        end
    end

    // rows fetched top index first, so row w_base+i settles in array row i
    always_ff @(posedge clk) begin
        if (state == load_idle && cmd.op == op_load_weights) begin
            rd_addr <= cmd.src_base + top_ofs;
        end else if (state == load_fetch) begin
            rd_addr <= rd_addr - 1'b1;
        end
    end

    // read data is the shift row, one cycle behind the address
    always_ff @(posedge clk) begin
        if (state == load_fetch) begin
            w_shift <= mem[rd_addr];
        end
    end

    assign w_shift_en  = (state == load_fetch) && (cnt != '0);
    assign w_commit    = (state == load_commit);
    assign weight_done = (state == load_commit);     // N+2 after cmd
    assign busy        = (state != load_idle);

    // commit comes right after an unbroken run of exactly N shifts
    a_commit_after_n : assert property (@(posedge clk) disable iff (!rst_n)
        w_commit |-> ($past(w_shift_en) && $past(w_shift_en, `MMU_N)
                      && !$past(w_shift_en, `MMU_N + 1)));

    a_shift_then_commit : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(w_shift_en) |-> w_commit);

endmodule

/* source/result_writer.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module result_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::wave_t      tag,
    input  mmu_pkg::sum_row_t   psum_out,
    input  logic [`MMU_AW-1:0]  rd_addr,
    output mmu_pkg::sum_row_t   rd_data,
    output logic                compute_done,
    output logic                busy
);
    import mmu_pkg::*;

    // N stages to reach column 0 then N-1 more riding with its deskew
    localparam int tag_stages = 2 * `MMU_N - 1;
    localparam int pw = `MMU_AW + 1;

    sum_row_t            omem [`MMU_DEPTH];   // output memory
    wave_t               tag_pipe [tag_stages];
    sum_row_t            aligned;             // all columns of one vector
    logic                wr_en;
    logic [`MMU_AW-1:0]  wr_addr;
    logic [pw-1:0]       pending;             // tags accepted but not yet written
    logic [pw-1:0]       pending_nxt;

    // =======================================================================
    // tag delay
    // =======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < tag_stages; s++) begin
                tag_pipe[s] <= '0;
            end
        end else begin
            tag_pipe[0] <= tag;
            for (int s = 1; s < tag_stages; s++) begin
                tag_pipe[s] <= tag_pipe[s-1];
            end
        end
    end

    // column j arrives j cycles after column 0 so it waits N-1-j
    for (genvar j = 0; j < `MMU_N; j++) begin : g_deskew
        if (j == `MMU_N - 1) begin : g_direct
            assign aligned[j] = psum_out[j];
        end else begin : g_delay
            sum_t pipe [`MMU_N-1-j];
            always_ff @(posedge clk) begin
                pipe[0] <= psum_out[j];
                for (int d = 1; d < `MMU_N - 1 - j; d++) begin
                    pipe[d] <= pipe[d-1];
                end
            end
            assign aligned[j] = pipe[`MMU_N-2-j];
        end
    end

    assign wr_en   = tag_pipe[tag_stages-1].valid;
    assign wr_addr = tag_pipe[tag_stages-1].dst_addr;

    // =======================================================================
    // output memory write side and host read port
    // =======================================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            omem[wr_addr] <= aligned;
        end
        rd_data <= omem[rd_addr];             // 1-cycle read latency
    end

    // outstanding vector count and done pulse
    always_comb begin
        pending_nxt = pending + pw'(tag.valid) - pw'(wr_en);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending      <= '0;
            compute_done <= 1'b0;
        end else begin
            pending      <= pending_nxt;
            compute_done <= wr_en && (pending_nxt == '0);   // cycle after last write
        end
    end

    assign busy = (pending != '0) || tag.valid;

    // a write always retires a tag still counted as outstanding
    a_wr_has_tag : assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (pending != '0));

endmodule

/* source/mmu_top.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module mmu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mmu_pkg::host_cmd_t  cmd,
    input  mmu_pkg::mem_wr_t    in_wr,
    input  mmu_pkg::mem_wr_t    wt_wr,
    input  logic [`MMU_AW-1:0]  rd_addr,
    output mmu_pkg::sum_row_t   rd_data,
    output logic                busy,
    output logic                weight_done,
    output logic                compute_done
);
    import mmu_pkg::*;

    act_row_t  a_in;          // skewed activations into array rows
    wave_t     tag;           // vector tag, feeder -> writer
    act_row_t  w_shift;       // top weight row
    logic      w_shift_en;
    logic      w_commit;
    sum_row_t  psum_out;      // column bottoms
    logic      feed_busy;
    logic      load_busy;
    logic      wr_busy;

    // =======================================================================
    // input side
    // =======================================================================
    activation_feeder feeder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .in_wr    (in_wr),
        .a_in     (a_in),
        .tag      (tag),
        .busy     (feed_busy)
    );

    weight_loader loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .wt_wr       (wt_wr),
        .w_shift     (w_shift),
        .w_shift_en  (w_shift_en),
        .w_commit    (w_commit),
        .weight_done (weight_done),
        .busy        (load_busy)
    );

    // =======================================================================
    // array and output side
    // =======================================================================
    systolic_array array_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_in       (a_in),
        .w_shift    (w_shift),
        .w_shift_en (w_shift_en),
        .w_commit   (w_commit),
        .psum_out   (psum_out)
    );

    result_writer writer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tag          (tag),
        .psum_out     (psum_out),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .compute_done (compute_done),
        .busy         (wr_busy)
    );

    assign busy = feed_busy | load_busy | wr_busy;   // any stage still working

endmodule

/* verification/mmu_clock.sv */
`timescale 1ns/10ps

module mmu_clock #(
    parameter int half_period  = 5,    // 10 ns clock
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // sync reset, let go on a falling edge like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verification/mmu_tb.sv */
`timescale 1ns/10ps
`include "mmu_config.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int num_cases  = 5;
    localparam int load_limit = 4 * `MMU_N + 10;   // give up on weight_done after this

    typedef enum logic [1:0] {fill_rand, fill_max, fill_min} fill_e;

    typedef struct packed {
        logic [`MMU_AW-1:0]  w_base;
        logic [`MMU_AW-1:0]  in_base;
        logic [`MMU_AW-1:0]  dst_base;
        logic [`MMU_AW:0]    count;
        fill_e               fill;
    } case_t;

    logic                clk;
    logic                rst_n;
    host_cmd_t           cmd;
    mem_wr_t             in_wr;
    mem_wr_t             wt_wr;
    logic [`MMU_AW-1:0]  rd_addr;
    sum_row_t            rd_data;
    logic                busy;
    logic                weight_done;
    logic                compute_done;

    case_t        cases [num_cases];
    act_row_t     in_model [`MMU_DEPTH];      // mirrors of the DUT memories
    act_row_t     wt_model [`MMU_DEPTH];
    sum_row_t     out_model [`MMU_DEPTH];
    logic         out_written [`MMU_DEPTH];   // rows some case has produced
    logic [31:0]  lcg_state;
    int           errors;
    int           checks;

    mmu_clock clock_i (.clk(clk), .rst_n(rst_n));

    mmu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .in_wr        (in_wr),
        .wt_wr        (wt_wr),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .busy         (busy),
        .weight_done  (weight_done),
        .compute_done (compute_done)
    );

    // ===========================================================================
    // stimulus table and reference model
    // ===========================================================================
    task automatic build_table();
        cases[0] = '{4'd0,  4'd0, 4'd0,  5'd16, fill_rand};  // full depth, many in flight
        cases[1] = '{4'd4,  4'd2, 4'd3,  5'd5,  fill_max};   // 4*127*127 wraps
        cases[2] = '{4'd8,  4'd8, 4'd10, 5'd6,  fill_min};   // 4*(-128)^2 wraps to 0
        cases[3] = '{4'd12, 4'd5, 4'd7,  5'd1,  fill_rand};  // new tile, single vector
        cases[4] = '{4'd2,  4'd7, 4'd6,  5'd9,  fill_rand};  // tile overlaps earlier ones
    endtask

    function automatic act_t next_rand_lane();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return $signed(lcg_state[23:16]);     // middle bits, low ones cycle fast
    endfunction

    function automatic act_row_t make_row(input fill_e fill);
        act_row_t row;
        for (int l = 0; l < `MMU_N; l++) begin
            case (fill)
                fill_max: row[l] = {1'b0, {(`MMU_DW-1){1'b1}}};
                fill_min: row[l] = {1'b1, {(`MMU_DW-1){1'b0}}};
                default:  row[l] = next_rand_lane();
            endcase
        end
        return row;
    endfunction

    // out[j] = sum_i a[i] * w[w_base+i][j], kept to the low sum bits
    function automatic sum_row_t expected_row(input act_row_t a,
                                              input logic [`MMU_AW-1:0] w_base);
        sum_row_t            res;
        logic [`MMU_AW-1:0]  wa;
        int                  acc;
        int                  av;
        int                  wv;
        for (int j = 0; j < `MMU_N; j++) begin
            acc = 0;
            for (int i = 0; i < `MMU_N; i++) begin
                wa  = w_base + `MMU_AW'(i);
                av  = a[i];                    // sign extends
                wv  = wt_model[wa][j];
                acc = acc + av * wv;
            end
            res[j] = acc[`MMU_SW-1:0];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ===========================================================================
    // host side tasks, all driving on the falling edge
    // ===========================================================================
    task automatic write_memories(input case_t c);
        logic [`MMU_AW-1:0] a;
        for (int r = 0; r < `MMU_N; r++) begin
            @(negedge clk);
            a = c.w_base + `MMU_AW'(r);
            wt_wr = '{en: 1'b1, addr: a, data: make_row(c.fill)};
            wt_model[a] = wt_wr.data;
        end
        @(negedge clk);
        wt_wr = '0;
        for (int k = 0; k < c.count; k++) begin
            a = c.in_base + `MMU_AW'(k);
            in_wr = '{en: 1'b1, addr: a, data: make_row(c.fill)};
            in_model[a] = in_wr.data;
            @(negedge clk);
        end
        in_wr = '0;
    endtask

    task automatic load_weights(input logic [`MMU_AW-1:0] w_base);
        int cycles;
        @(negedge clk);
        cmd.op       = op_load_weights;
        cmd.src_base = w_base;
        cmd.dst_base = '0;
        cmd.count    = '0;
        @(negedge clk);
        cmd    = '0;                           // strobe lasts one cycle
        cycles = 1;
        while (!weight_done && cycles <= load_limit) begin
            check_value("busy while loading weights", busy, 1'b1);
            @(negedge clk);
            cycles++;
        end
        if (!weight_done) begin
            errors++;
            $display("weight_done never came after load command at %0t ns", $time);
        end else begin
            check_value("weight_done latency in cycles", cycles, `MMU_N + 2);
        end
        @(negedge clk);
        check_value("weight_done one cycle wide", weight_done, 1'b0);
        check_value("busy after weight load", busy, 1'b0);
    endtask

    task automatic run_compute(input case_t c);
        int                  cycles;
        logic [`MMU_AW-1:0]  src;
        logic [`MMU_AW-1:0]  dst;
        @(negedge clk);
        cmd.op       = op_compute;
        cmd.src_base = c.in_base;
        cmd.dst_base = c.dst_base;
        cmd.count    = c.count;
        @(negedge clk);
        cmd    = '0;
        cycles = 1;
        while (!compute_done && cycles < c.count + 2 * `MMU_N + 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!compute_done) begin
            errors++;
            $display("compute_done never came after compute command at %0t ns", $time);
        end
        @(negedge clk);
        check_value("compute_done one cycle wide", compute_done, 1'b0);
        check_value("busy after compute", busy, 1'b0);
        // model: only the rows of this case change
        for (int k = 0; k < c.count; k++) begin
            src = c.in_base + `MMU_AW'(k);
            dst = c.dst_base + `MMU_AW'(k);
            out_model[dst]   = expected_row(in_model[src], c.w_base);
            out_written[dst] = 1'b1;
        end
    endtask

    // whole output memory, one address per cycle, data a cycle later
    task automatic read_back(input int case_idx);
        sum_row_t got;
        @(negedge clk);
        rd_addr = '0;
        for (int a = 0; a < `MMU_DEPTH; a++) begin
            @(negedge clk);
            got = rd_data;
            if (a + 1 < `MMU_DEPTH) begin
                rd_addr = `MMU_AW'(a + 1);
            end
            if (out_written[a]) begin
                check_value($sformatf("case %0d output row %0d", case_idx, a),
                            got, out_model[a]);
            end
        end
    endtask

    // ===========================================================================
    // main sequence
    // ===========================================================================
    initial begin
        cmd       = '0;
        in_wr     = '0;
        wt_wr     = '0;
        rd_addr   = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'ha28489fe;
        for (int r = 0; r < `MMU_DEPTH; r++) begin
            out_written[r] = 1'b0;
        end
        build_table();
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("busy after reset", busy, 1'b0);
        check_value("weight_done after reset", weight_done, 1'b0);
        check_value("compute_done after reset", compute_done, 1'b0);
        for (int c = 0; c < num_cases; c++) begin
            write_memories(cases[c]);
            load_weights(cases[c].w_base);
            run_compute(cases[c]);
            read_back(c);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog, budget scales with each case's vector count
    initial begin
        int budget;
        wait (rst_n === 1'b1);
        budget = 100;
        for (int c = 0; c < num_cases; c++) begin
            budget += cases[c].count + 2 * `MMU_N + 40;   // load and compute
            budget += 2 * `MMU_DEPTH + `MMU_N;           // writes and read back
        end
        repeat (budget) @(posedge clk);
        $display("timeout: run still going after %0d cycles, a done pulse went missing",
                 budget);
        $display("Checks failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/mmu_pkg.sv
source/mac_cell.sv
source/systolic_array.sv
source/activation_feeder.sv
source/weight_loader.sv
source/result_writer.sv
source/mmu_top.sv
verification/mmu_clock.sv
verification/mmu_tb.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vmmu_tb: verilog.f $(wildcard source/*.sv source/*.svh verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb -f verilog.f

run: obj_dir/Vmmu_tb
	obj_dir/Vmmu_tb | tee sim.log
	! grep -q "Checks failed" sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
